// File: thread_sys.f
thread_sys_cpu_pkg.sv
thread_sys_msg_pkg.sv
thread_sys_seq.sv
thread_ctlr.sv
thread_dispatcher.sv
thread_sys_top.sv
thread_sys_chk.sv
thread_sys_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= thread_sys_tb
FILELIST  ?= thread_sys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: thread_sys_tb.sv
`timescale 1ns/100ps

module thread_sys_tb;

  import thread_sys_cpu_pkg::*;
  import thread_sys_msg_pkg::*;

  localparam int RESET_CYCLES   = 5;
  localparam int NUM_CMDS       = 200;
  localparam int TIMEOUT_CYCLES = NUM_CMDS * 12 + RESET_CYCLES + NUM_THREADS;
  localparam int NOP_LATENCY    = 4;
  localparam int MSG_LATENCY    = 7;
  localparam logic [31:0] BASE_A = 32'h1000_0000;
  localparam logic [31:0] BASE_B = 32'h2000_0000;

  logic                  clk;
  logic                  rst;
  logic                  cmd_strobe;
  cmd_word_t             command;
  logic [DATA_SIZE-1:0]  src0;
  logic [DATA_SIZE-1:0]  src1;
  logic [ADDR_SIZE-1:0]  base_addr;
  logic [ADDR_SIZE-1:0]  base_addr_data;
  logic                  busy;
  logic                  cmd_done;
  logic                  cmd_ok;
  logic [2:0]            thread_count;
  cpu_msg_t              cpu_msg_out;
  logic                  cpu_msg_pulse;

  // reference thread table
  logic                  model_valid [NUM_THREADS];
  logic [ADDR_SIZE-1:0]  model_addr  [NUM_THREADS];
  int                    model_count;

  int seed;
  int cmd_idx;
  int cycle_count;
  int fail_count;

  thread_sys_top u_dut (
    .clk            (clk),
    .rst            (rst),
    .cmd_strobe     (cmd_strobe),
    .command        (command),
    .src0           (src0),
    .src1           (src1),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .busy           (busy),
    .cmd_done       (cmd_done),
    .cmd_ok         (cmd_ok),
    .thread_count   (thread_count),
    .cpu_msg_out    (cpu_msg_out),
    .cpu_msg_pulse  (cpu_msg_pulse)
  );

  bind thread_sys_top thread_sys_chk u_chk (
    .clk           (clk),
    .rst           (rst),
    .busy          (busy),
    .cmd_done      (cmd_done),
    .cpu_msg_pulse (cpu_msg_pulse),
    .cpu_msg_out   (cpu_msg_out)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_failure(input string what);
    fail_count++;
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_msg(input string name, input cpu_msg_t exp, input cpu_msg_t act);
    if (act !== exp) begin
      report_failure($sformatf(
        "MISMATCH %s: expected code=%h addr=%h data=%h actual code=%h addr=%h data=%h",
        name, exp.code, exp.addr, exp.data, act.code, act.addr, act.data));
    end
  endtask

  task automatic check_result(input string name, input logic exp_ok, input logic [2:0] exp_cnt,
                              input logic act_ok, input logic [2:0] act_cnt);
    if (act_ok !== exp_ok || act_cnt !== exp_cnt) begin
      report_failure($sformatf("MISMATCH %s: expected ok=%b count=%0d actual ok=%b count=%0d",
                               name, exp_ok, exp_cnt, act_ok, act_cnt));
    end
  endtask

  task automatic check_bool(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("MISMATCH %s: expected %b actual %b", name, exp, act));
    end
  endtask

  // latencies and pulse counts
  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      report_failure($sformatf("MISMATCH %s: expected %0d actual %0d", name, exp, act));
    end
  endtask

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("timeout after %0d cycles, commands stopped completing",
                               cycle_count));
    end
  end

  function automatic int unsigned rand_below(input int unsigned range);
    return $unsigned($random(seed)) % range;
  endfunction

  // lowest free slot takes the fork
  task automatic reserve_slot(input logic [ADDR_SIZE-1:0] key, output logic ok);
    ok = 1'b0;
    for (int i = 0; i < NUM_THREADS; i++) begin
      if (!ok && !model_valid[i]) begin
        model_valid[i] = 1'b1;
        model_addr[i]  = key;
        ok             = 1'b1;
      end
    end
    if (ok) model_count++;
  endtask

  // lowest matching slot is freed
  task automatic release_slot(input logic [ADDR_SIZE-1:0] key, output logic ok);
    ok = 1'b0;
    for (int i = 0; i < NUM_THREADS; i++) begin
      if (!ok && model_valid[i] && model_addr[i] == key) begin
        model_valid[i] = 1'b0;
        ok             = 1'b1;
      end
    end
    if (ok) model_count--;
  endtask

  // strobes during alu_begin must not start another command
  task automatic drive_stray_strobe();
    if (rand_below(4) == 0) begin
      cmd_strobe <= 1'b1;
      command    <= '{op: CMD_FORK, rsvd: 28'(rand_below(256))};
      src0       <= 32'h40 * (1 + rand_below(4));
      src1       <= $random(seed);
    end else begin
      cmd_strobe <= 1'b0;
    end
  endtask

  task automatic run_command(input cmd_op_e op, input logic [31:0] s0, input logic [31:0] s1,
                             input logic [31:0] ba, input logic [31:0] bad,
                             input bit wait_online);
    cpu_msg_t exp_msg;
    logic     exp_ok;
    logic     sends;
    int       cycles;
    int       pulses;
    string    tag;
    tag   = $sformatf("cmd %0d %s", cmd_idx, op.name());
    sends = 1'b1;
    case (op)
      CMD_FORK: begin
        exp_msg.code = MSG_FORK_THRD;
        exp_msg.addr = s0 + ba;
        exp_msg.data = (s1 == 32'd0) ? 32'd0 : s1 + bad;
        reserve_slot(exp_msg.addr, exp_ok);
      end
      CMD_STOP: begin
        exp_msg.code = MSG_STOP_THRD;
        exp_msg.addr = s0 + ba - 32'(THREAD_HEADER_SPACE);
        exp_msg.data = (s1 == 32'd0) ? bad - 32'(THREAD_HEADER_SPACE) :
                       s1 + bad - 32'(THREAD_HEADER_SPACE);
        // dispatcher matches one header above the stop address
        release_slot(exp_msg.addr + 32'(THREAD_HEADER_SPACE), exp_ok);
      end
      default: begin
        exp_msg = '0;
        exp_ok  = 1'b1;
        sends   = 1'b0;
      end
    endcase
    @(posedge clk);
    cmd_strobe     <= 1'b1;
    command        <= '{op: op, rsvd: 28'($random(seed))};
    src0           <= s0;
    src1           <= s1;
    base_addr      <= ba;
    base_addr_data <= bad;
    // strobe is taken on this edge
    @(posedge clk);
    cmd_strobe <= 1'b0;
    cycles = 0;
    pulses = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cpu_msg_pulse === 1'b1) begin
        pulses++;
        check_msg({tag, " message"}, exp_msg, cpu_msg_out);
      end else begin
        check_msg({tag, " quiet bus"}, '0, cpu_msg_out);
      end
      if (cmd_done !== 1'b1) begin
        check_bool({tag, " busy"}, 1'b1, busy);
        @(posedge clk);
        drive_stray_strobe();
      end
    end while (cmd_done !== 1'b1);
    check_result({tag, " result"}, exp_ok, 3'(model_count), cmd_ok, thread_count);
    check_count({tag, " pulses"}, sends ? 1 : 0, pulses);
    if (wait_online) begin
      if (cycles <= NOP_LATENCY) begin
        report_failure($sformatf("%s completed in %0d cycles, before the table clear ended",
                                 tag, cycles));
      end
    end else begin
      check_count({tag, " latency"}, sends ? MSG_LATENCY : NOP_LATENCY, cycles);
    end
    // stray strobe from write back is dropped here
    @(posedge clk);
    cmd_strobe <= 1'b0;
    @(negedge clk);
    check_bool({tag, " done width"}, 1'b0, cmd_done);
    check_bool({tag, " idle"}, 1'b0, busy);
    cmd_idx++;
  endtask

  task automatic run_random_command();
    int unsigned pick;
    cmd_op_e     op;
    logic [31:0] s0;
    logic [31:0] s1;
    logic [31:0] ba;
    pick = rand_below(10);
    // mostly forks and stops
    if (pick < 4) op = CMD_FORK;
    else if (pick < 8) op = CMD_STOP;
    else if (pick == 8) op = CMD_NOP;
    else op = cmd_op_e'(4'(3 + rand_below(5)));
    // few addresses so stops hit earlier forks
    s0 = 32'h40 * (1 + rand_below(4));
    s1 = (rand_below(4) == 0) ? 32'd0 : $random(seed);
    ba = (rand_below(2) == 0) ? BASE_A : BASE_B;
    run_command(op, s0, s1, ba, $random(seed), 1'b0);
  endtask

  initial begin
    seed           = 46;
    rst            = 1'b1;
    cmd_strobe     = 1'b0;
    command        = '0;
    src0           = '0;
    src1           = '0;
    base_addr      = '0;
    base_addr_data = '0;
    for (int i = 0; i < NUM_THREADS; i++) begin
      model_valid[i] = 1'b0;
      model_addr[i]  = '0;
    end
    model_count = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_bool("reset busy", 1'b0, busy);
    check_bool("reset cmd_done", 1'b0, cmd_done);
    check_bool("reset pulse", 1'b0, cpu_msg_pulse);
    check_result("reset table", 1'b0, 3'd0, cmd_ok, thread_count);
    // dispatcher is still clearing its table
    run_command(CMD_NOP, 32'h40, 32'h0, BASE_A, 32'h0, 1'b1);
    // fill the table and send one more fork that finds no slot
    for (int i = 1; i <= NUM_THREADS + 1; i++) begin
      run_command(CMD_FORK, 32'h40 * i, 32'h100 * i, BASE_A, 32'h3000_0000, 1'b0);
    end
    // no thread at this address
    run_command(CMD_STOP, 32'h800, 32'h5, BASE_A, 32'h3000_0000, 1'b0);
    // src1 zero form of the stop data
    run_command(CMD_STOP, 32'h40, 32'h0, BASE_A, 32'h3000_0000, 1'b0);
    run_command(CMD_RSV5, 32'h80, 32'h7, BASE_B, 32'h0, 1'b0);
    while (cmd_idx < NUM_CMDS) begin
      run_random_command();
    end
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: thread_sys_chk.sv
`timescale 1ns/100ps

module thread_sys_chk (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           busy,
  input  logic                           cmd_done,
  input  logic                           cpu_msg_pulse,
  input  thread_sys_msg_pkg::cpu_msg_t   cpu_msg_out
);

  // one message per command, never back to back
  a_pulse_single: assert property (@(posedge clk) disable iff (rst)
    cpu_msg_pulse |=> !cpu_msg_pulse)
    else $error("cpu_msg_pulse high on two consecutive cycles");

  // write back is a single cycle
  a_done_single: assert property (@(posedge clk) disable iff (rst)
    cmd_done |=> !cmd_done)
    else $error("cmd_done held for more than one cycle");

  // sequencer sits in idle once reset is applied
  a_idle_after_reset: assert property (@(posedge clk)
    rst |=> !busy)
    else $error("busy high in the cycle after reset");

  // bus reads zero between pulses
  a_msg_quiet: assert property (@(posedge clk) disable iff (rst)
    !cpu_msg_pulse |-> (cpu_msg_out.addr == '0 && cpu_msg_out.data == '0))
    else $error("message addr or data nonzero while cpu_msg_pulse is low");

endmodule

// File: thread_sys_top.sv
`timescale 1ns/100ps

module thread_sys_top (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       cmd_strobe,
  input  thread_sys_cpu_pkg::cmd_word_t              command,
  input  logic [thread_sys_cpu_pkg::DATA_SIZE-1:0]   src0,
  input  logic [thread_sys_cpu_pkg::DATA_SIZE-1:0]   src1,
  input  logic [thread_sys_cpu_pkg::ADDR_SIZE-1:0]   base_addr,
  input  logic [thread_sys_cpu_pkg::ADDR_SIZE-1:0]   base_addr_data,
  output logic                                       busy,
  output logic                                       cmd_done,
  output logic                                       cmd_ok,
  output logic [2:0]                                 thread_count,
  output thread_sys_msg_pkg::cpu_msg_t               cpu_msg_out,
  output logic                                       cpu_msg_pulse
);

  import thread_sys_cpu_pkg::*;
  import thread_sys_msg_pkg::*;

  // sequencer to controller
  exec_state_e           state;
  cmd_word_t             cmd_reg;
  logic [DATA_SIZE-1:0]  src0_reg;
  logic [DATA_SIZE-1:0]  src1_reg;

  // controller back to sequencer
  logic                  next_state;
  logic                  result_ok;

  // dispatcher back to controller
  reply_t                reply;
  logic                  disp_online;

  thread_sys_seq u_seq (
    .clk        (clk),
    .rst        (rst),
    .cmd_strobe (cmd_strobe),
    .command    (command),
    .src0       (src0),
    .src1       (src1),
    .next_state (next_state),
    .result_ok  (result_ok),
    .state      (state),
    .cmd_reg    (cmd_reg),
    .src0_reg   (src0_reg),
    .src1_reg   (src1_reg),
    .busy       (busy),
    .cmd_done   (cmd_done),
    .cmd_ok     (cmd_ok)
  );

  thread_ctlr u_ctlr (
    .clk            (clk),
    .rst            (rst),
    .state          (state),
    .command        (cmd_reg),
    .src0           (src0_reg),
    .src1           (src1_reg),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .disp_online    (disp_online),
    .reply          (reply),
    .cpu_msg_out    (cpu_msg_out),
    .cpu_msg_pulse  (cpu_msg_pulse),
    .next_state     (next_state),
    .result_ok      (result_ok)
  );

  thread_dispatcher u_disp (
    .clk           (clk),
    .rst           (rst),
    .cpu_msg_in    (cpu_msg_out),
    .cpu_msg_pulse (cpu_msg_pulse),
    .reply         (reply),
    .disp_online   (disp_online),
    .thread_count  (thread_count)
  );

endmodule

// File: thread_dispatcher.sv
`timescale 1ns/100ps

module thread_dispatcher (
  input  logic                           clk,
  input  logic                           rst,
  input  thread_sys_msg_pkg::cpu_msg_t   cpu_msg_in,
  input  logic                           cpu_msg_pulse,
  output thread_sys_msg_pkg::reply_t     reply,
  output logic                           disp_online,
  output logic [2:0]                     thread_count
);

  import thread_sys_cpu_pkg::*;
  import thread_sys_msg_pkg::*;

  // thread table
  logic [NUM_THREADS-1:0] slot_valid;
  logic [ADDR_SIZE-1:0]   slot_addr [NUM_THREADS];

  // clear sweep after reset
  logic [SLOT_W-1:0]      clr_idx;

  // pending reply
  logic [DISP_CNT_W-1:0]  cnt;
  cpu_msg_e               pend_code;
  logic                   pend_ok;

  logic                   cap_fork;
  logic                   cap_stop;
  logic                   free_hit;
  logic [SLOT_W-1:0]      free_idx;
  logic                   stop_hit;
  logic [SLOT_W-1:0]      stop_idx;
  logic [ADDR_SIZE-1:0]   stop_key;

  assign cap_fork = cpu_msg_pulse && disp_online && (cpu_msg_in.code == MSG_FORK_THRD);
  assign cap_stop = cpu_msg_pulse && disp_online && (cpu_msg_in.code == MSG_STOP_THRD);

  // stop address points below the header of the forked thread
  assign stop_key = cpu_msg_in.addr + ADDR_SIZE'(THREAD_HEADER_SPACE);

  // lowest free slot and matching stop slot, scan from top so lowest wins
  always_comb begin
    free_hit = 1'b0;
    free_idx = '0;
    stop_hit = 1'b0;
    stop_idx = '0;
    for (int i = NUM_THREADS - 1; i >= 0; i--) begin
      if (!slot_valid[i]) begin
        free_hit = 1'b1;
        free_idx = SLOT_W'(i);
      end
      if (slot_valid[i] && slot_addr[i] == stop_key) begin
        stop_hit = 1'b1;
        stop_idx = SLOT_W'(i);
      end
    end
  end

  // table contents, cleared by the sweep
  always_ff @(posedge clk) begin
    if (!disp_online) begin
      slot_valid[clr_idx] <= 1'b0;
    end else if (cap_fork) begin
      if (free_hit) begin
        slot_valid[free_idx] <= 1'b1;
        slot_addr[free_idx]  <= cpu_msg_in.addr;
      end
      pend_code <= MSG_FORK_DONE;
      pend_ok   <= free_hit;
    end else if (cap_stop) begin
      if (stop_hit) begin
        slot_valid[stop_idx] <= 1'b0;
      end
      pend_code <= MSG_STOP_DONE;
      pend_ok   <= stop_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      clr_idx      <= '0;
      disp_online  <= 1'b0;
      thread_count <= 3'd0;
      cnt          <= '0;
      reply        <= '{code: MSG_NONE, ok: 1'b0};
    end else begin
      // reply is a single-cycle event
      reply <= '{code: MSG_NONE, ok: 1'b0};
      if (!disp_online) begin
        clr_idx <= clr_idx + 1'b1;
        if (clr_idx == SLOT_W'(NUM_THREADS - 1)) begin
          disp_online <= 1'b1;
        end
      end
      if (cap_fork || cap_stop) begin
        cnt <= DISP_CNT_W'(DISP_LATENCY - 1);
        if (cap_fork && free_hit) begin
          thread_count <= thread_count + 3'd1;
        end
        if (cap_stop && stop_hit) begin
          thread_count <= thread_count - 3'd1;
        end
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
        // last count, answer goes out next cycle
        if (cnt == DISP_CNT_W'(1)) begin
          reply <= '{code: pend_code, ok: pend_ok};
        end
      end
    end
  end

endmodule

// File: thread_ctlr.sv
`timescale 1ns/100ps

module thread_ctlr (
  input  logic                                       clk,
  input  logic                                       rst,
  input  thread_sys_cpu_pkg::exec_state_e            state,
  input  thread_sys_cpu_pkg::cmd_word_t              command,
  input  logic [thread_sys_cpu_pkg::DATA_SIZE-1:0]   src0,
  input  logic [thread_sys_cpu_pkg::DATA_SIZE-1:0]   src1,
  input  logic [thread_sys_cpu_pkg::ADDR_SIZE-1:0]   base_addr,
  input  logic [thread_sys_cpu_pkg::ADDR_SIZE-1:0]   base_addr_data,
  input  logic                                       disp_online,
  input  thread_sys_msg_pkg::reply_t                 reply,
  output thread_sys_msg_pkg::cpu_msg_t               cpu_msg_out,
  output logic                                       cpu_msg_pulse,
  output logic                                       next_state,
  output logic                                       result_ok
);

  import thread_sys_cpu_pkg::*;
  import thread_sys_msg_pkg::*;

  cpu_msg_e              msg_code_q;
  logic [ADDR_SIZE-1:0]  addr_q;
  logic [DATA_SIZE-1:0]  data_q;
  // one message per command
  logic                  signal_sent;
  logic                  next_state_q;
  logic                  result_ok_q;

  logic [ADDR_SIZE-1:0]  fork_addr;
  logic [DATA_SIZE-1:0]  fork_data;
  logic [ADDR_SIZE-1:0]  stop_addr;
  logic [DATA_SIZE-1:0]  stop_data;
  logic                  needs_reply;
  cpu_msg_e              done_code;
  logic                  finish;

  // message payloads from operands and base addresses
  assign fork_addr = src0 + base_addr;
  assign fork_data = (src1 == '0) ? '0 : src1 + base_addr_data;
  assign stop_addr = src0 + base_addr - ADDR_SIZE'(THREAD_HEADER_SPACE);
  assign stop_data = (src1 == '0) ?
                     base_addr_data - DATA_SIZE'(THREAD_HEADER_SPACE) :
                     src1 + base_addr_data - DATA_SIZE'(THREAD_HEADER_SPACE);

  // which DONE code closes the current command
  always_comb begin
    case (command.op)
      CMD_FORK: done_code = MSG_FORK_DONE;
      CMD_STOP: done_code = MSG_STOP_DONE;
      default:  done_code = MSG_NONE;
    endcase
  end

  assign needs_reply = (command.op == CMD_FORK) || (command.op == CMD_STOP);
  // nop and reserved ops finish one cycle after the issue slot
  assign finish = !needs_reply || (reply.code == done_code);

  always_ff @(posedge clk) begin
    if (rst) begin
      msg_code_q    <= MSG_NONE;
      cpu_msg_pulse <= 1'b0;
      signal_sent   <= 1'b0;
      next_state_q  <= 1'b0;
      result_ok_q   <= 1'b0;
    end else begin
      // pulses default low
      msg_code_q    <= MSG_NONE;
      cpu_msg_pulse <= 1'b0;
      next_state_q  <= 1'b0;
      // skip the cycle where next_state is out, state still reads alu_begin
      if (state == ALU_BEGIN && !next_state_q && disp_online) begin
        if (!signal_sent) begin
          signal_sent <= 1'b1;
          case (command.op)
            CMD_FORK: begin
              addr_q        <= fork_addr;
              data_q        <= fork_data;
              msg_code_q    <= MSG_FORK_THRD;
              cpu_msg_pulse <= 1'b1;
            end
            CMD_STOP: begin
              addr_q        <= stop_addr;
              data_q        <= stop_data;
              msg_code_q    <= MSG_STOP_THRD;
              cpu_msg_pulse <= 1'b1;
            end
            // nothing to send
            default: begin
              msg_code_q <= MSG_NONE;
            end
          endcase
        end else if (finish) begin
          signal_sent  <= 1'b0;
          next_state_q <= 1'b1;
          result_ok_q  <= needs_reply ? reply.ok : 1'b1;
        end
      end
    end
  end

  // addr and data read zero outside the pulse
  assign cpu_msg_out = '{code: msg_code_q,
                         addr: cpu_msg_pulse ? addr_q : '0,
                         data: cpu_msg_pulse ? data_q : '0};

  assign next_state = next_state_q;
  assign result_ok  = result_ok_q;

endmodule

// File: thread_sys_seq.sv
`timescale 1ns/100ps

module thread_sys_seq (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       cmd_strobe,
  input  thread_sys_cpu_pkg::cmd_word_t              command,
  input  logic [thread_sys_cpu_pkg::DATA_SIZE-1:0]   src0,
  input  logic [thread_sys_cpu_pkg::DATA_SIZE-1:0]   src1,
  input  logic                                       next_state,
  input  logic                                       result_ok,
  output thread_sys_cpu_pkg::exec_state_e            state,
  output thread_sys_cpu_pkg::cmd_word_t              cmd_reg,
  output logic [thread_sys_cpu_pkg::DATA_SIZE-1:0]   src0_reg,
  output logic [thread_sys_cpu_pkg::DATA_SIZE-1:0]   src1_reg,
  output logic                                       busy,
  output logic                                       cmd_done,
  output logic                                       cmd_ok
);

  import thread_sys_cpu_pkg::*;

  // result of the command, captured with next_state
  logic ok_q;

  logic accept;

  // strobes outside idle are dropped
  assign accept = (state == IDLE) && cmd_strobe;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      ok_q  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= ALU_BEGIN;
          end
        end
        // controller owns the timing here
        ALU_BEGIN: begin
          if (next_state) begin
            ok_q  <= result_ok;
            state <= WRITE_BACK;
          end
        end
        WRITE_BACK: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // command and operands stay put until the next accepted strobe
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_reg  <= command;
      src0_reg <= src0;
      src1_reg <= src1;
    end
  end

  assign busy     = (state != IDLE);
  // write back lasts a single cycle
  assign cmd_done = (state == WRITE_BACK);
  assign cmd_ok   = (state == WRITE_BACK) && ok_q;

endmodule

// File: thread_sys_msg_pkg.sv
package thread_sys_msg_pkg;

  // inter-cpu message codes
  typedef enum logic [3:0] {
    MSG_NONE      = 4'h0,
    MSG_FORK_THRD = 4'h1,
    MSG_STOP_THRD = 4'h2,
    MSG_FORK_DONE = 4'h3,
    MSG_STOP_DONE = 4'h4
  } cpu_msg_e;

  // request from controller to dispatcher
  typedef struct packed {
    cpu_msg_e    code;
    logic [31:0] addr;
    logic [31:0] data;
  } cpu_msg_t;

  // dispatcher answer, ok low means the request failed
  typedef struct packed {
    cpu_msg_e code;
    logic     ok;
  } reply_t;

  // dispatcher sizing and service delay
  localparam int NUM_THREADS  = 4;
  localparam int DISP_LATENCY = 3;
  localparam int SLOT_W       = $clog2(NUM_THREADS);
  localparam int DISP_CNT_W   = $clog2(DISP_LATENCY);

endpackage

// File: thread_sys_cpu_pkg.sv
package thread_sys_cpu_pkg;

  // datapath widths
  localparam int ADDR_SIZE = 32;
  localparam int DATA_SIZE = 32;

  // bytes in front of each thread body
  localparam int THREAD_HEADER_SPACE = 16;

  // execute states seen by the thread controller
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    ALU_BEGIN  = 2'd1,
    WRITE_BACK = 2'd2
  } exec_state_e;

  // command opcodes, top nibble of the command word
  // reserved codes complete like a nop
  typedef enum logic [3:0] {
    CMD_NOP  = 4'h0,
    CMD_FORK = 4'h1,
    CMD_STOP = 4'h2,
    CMD_RSV3 = 4'h3,
    CMD_RSV4 = 4'h4,
    CMD_RSV5 = 4'h5,
    CMD_RSV6 = 4'h6,
    CMD_RSV7 = 4'h7
  } cmd_op_e;

  // opcode in bits 31:28, rest not decoded here
  typedef struct packed {
    cmd_op_e     op;
    logic [27:0] rsvd;
  } cmd_word_t;

endpackage
